//--- hdl/audioMixer.sv
/*
 * CD audio mixer
 * Pops both PCM FIFOs on a fixed sample tick, applies the
 * cross-channel volumes, clips to 16 bits and registers the result
 */
`timescale 1ns/1ns
`default_nettype none

module audioMixer
    import audioPkg::*;
#(
    parameter int SAMPLE_PERIOD  = 768,
    parameter int PCM_DEPTH_LOG2 = 13
) (
    input  wire         i_clk,
    input  wire         i_nrst,
    input  mixVolume_t  i_volume,
    input  wire         i_pcmWriteL,
    input  wire         i_pcmWriteR,
    input  sample_t     i_pcmL,
    input  sample_t     i_pcmR,
    output logic        o_pcmFull,
    output sample_t     o_outL,
    output sample_t     o_outR,
    output logic        o_sampleValid
);

    localparam int CNT_W = (SAMPLE_PERIOD > 1) ? $clog2(SAMPLE_PERIOD) : 1;

    // Volume times sample, back to integer scale
    function automatic logic signed [17:0] scale(input volume_t vol, input sample_t smp);
        logic signed [24:0] prod;
        logic signed [24:0] shifted;
        prod    = $signed({1'b0, vol}) * smp;   // Volume is unsigned
        shifted = prod >>> VOL_FRAC_BITS;
        return shifted[17:0];                   // Max 255/128 * 32768 fits
    endfunction

    // Saturate a mix sum to the sample range
    function automatic sample_t clip(input logic signed [17:0] val);
        if (val > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end else if (val < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return val[15:0];
    endfunction

    logic [CNT_W-1:0]   tickCnt;
    logic               tick;
    logic               validL;
    logic               validR;
    logic               fullL;
    logic               fullR;
    sample_t            headL;
    sample_t            headR;
    sample_t            audioL;
    sample_t            audioR;
    logic signed [17:0] sumL;
    logic signed [17:0] sumR;

    // ----------------------------------------
    // Sample tick
    // ----------------------------------------
    assign tick = (tickCnt == CNT_W'(SAMPLE_PERIOD - 1));

    always_ff @(posedge i_clk) begin
        if (!i_nrst) begin
            tickCnt <= '0;
        end else if (tick) begin
            tickCnt <= '0;
        end else begin
            tickCnt <= tickCnt + 1'b1;
        end
    end

    // ----------------------------------------
    // PCM FIFOs
    // ----------------------------------------
    syncFifo #(
        .DATA_WIDTH ($bits(sample_t)),
        .DEPTH_LOG2 (PCM_DEPTH_LOG2)
    ) pcmFifoL (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (1'b0),
        .i_push  (i_pcmWriteL),
        .i_wData (i_pcmL),
        .i_pop   (tick && validL),  // One sample per tick
        .o_rData (headL),
        .o_valid (validL),
        .o_full  (fullL)
    );

    syncFifo #(
        .DATA_WIDTH ($bits(sample_t)),
        .DEPTH_LOG2 (PCM_DEPTH_LOG2)
    ) pcmFifoR (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (1'b0),
        .i_push  (i_pcmWriteR),
        .i_wData (i_pcmR),
        .i_pop   (tick && validR),
        .o_rData (headR),
        .o_valid (validR),
        .o_full  (fullR)
    );

    assign o_pcmFull = fullL | fullR;   // Writer must hold off

    // ----------------------------------------
    // Mix and clip
    // ----------------------------------------
    assign audioL = validL ? headL : '0;    // Underrun plays silence
    assign audioR = validR ? headR : '0;

    assign sumL = scale(i_volume.ll, audioL) + scale(i_volume.rl, audioR);
    assign sumR = scale(i_volume.lr, audioL) + scale(i_volume.rr, audioR);

    always_ff @(posedge i_clk) begin
        if (!i_nrst) begin
            o_sampleValid <= 1'b0;
        end else begin
            o_sampleValid <= tick;      // One cycle behind the tick
        end
    end

    always_ff @(posedge i_clk) begin
        if (tick) begin
            o_outL <= clip(sumL);
            o_outR <= clip(sumR);
        end
    end

endmodule

`default_nettype wire

//--- hdl/audioPkg.sv
/*
 * Audio package for the CD front end
 * PCM sample and volume types, the mixing volume set
 * and the fixed-point limits used by the mixer
 */
`default_nettype none

package audioPkg;

    // ----------------------------------------
    // Sample and volume types
    // ----------------------------------------
    typedef logic signed [15:0] sample_t;   // Signed 16 bit PCM
    typedef logic [7:0]         volume_t;   // Unsigned, 80h = 1.0

    // 7 bit fraction, so 80h lands on unity gain
    localparam int VOL_FRAC_BITS = 7;

    // Clip range of one output sample
    localparam int SAMPLE_MAX = 32767;
    localparam int SAMPLE_MIN = -32768;

    // ----------------------------------------
    // Cross-channel volume set
    // ----------------------------------------
    typedef struct packed {
        volume_t ll;    // Left in  -> left out
        volume_t lr;    // Left in  -> right out
        volume_t rl;    // Right in -> left out
        volume_t rr;    // Right in -> right out
    } mixVolume_t;

endpackage

`default_nettype wire

//--- hdl/cdromFrontEnd.sv
/*
 * CD drive host front end, top level
 * Host registers, parameter and response FIFOs, audio mixer
 */
`timescale 1ns/1ns
`default_nettype none

module cdromFrontEnd
    import cdromPkg::*;
    import audioPkg::*;
#(
    parameter int SAMPLE_PERIOD  = 768,     // Cycles per output sample
    parameter int PCM_DEPTH_LOG2 = 13
) (
    input  wire         i_clk,
    input  wire         i_nrst,
    // CPU side
    input  hostBus_t    i_bus,
    output hostByte_t   o_dataOut,
    // Drive side
    input  driveIn_t    i_drive,
    output driveOut_t   o_drive,
    // Audio out
    output sample_t     o_outL,
    output sample_t     o_outR,
    output logic        o_sampleValid
);

    hostByte_t  paramData;
    logic       paramValid;
    logic       paramFull;
    logic       paramPush;
    logic       paramClear;
    hostByte_t  respData;
    logic       respValid;
    logic       respPop;
    logic       pcmFull;
    mixVolume_t volume;

    assign o_drive = '{paramData: paramData, paramValid: paramValid, pcmFull: pcmFull};

    // ----------------------------------------
    // Host registers
    // ----------------------------------------
    hostRegisters regs (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_bus        (i_bus),
        .o_dataOut    (o_dataOut),
        .i_paramFull  (paramFull),
        .i_paramValid (paramValid),
        .o_paramPush  (paramPush),
        .o_paramClear (paramClear),
        .i_respData   (respData),
        .i_respValid  (respValid),
        .o_respPop    (respPop),
        .o_volume     (volume)
    );

    // ----------------------------------------
    // Command FIFOs
    // ----------------------------------------
    syncFifo #(
        .DATA_WIDTH ($bits(hostByte_t)),
        .DEPTH_LOG2 (CMD_FIFO_DEPTH_LOG2)
    ) paramFifo (                           // CPU in, drive out
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (paramClear),
        .i_push  (paramPush),
        .i_wData (i_bus.data),
        .i_pop   (i_drive.paramRead),
        .o_rData (paramData),
        .o_valid (paramValid),
        .o_full  (paramFull)
    );

    syncFifo #(
        .DATA_WIDTH ($bits(hostByte_t)),
        .DEPTH_LOG2 (CMD_FIFO_DEPTH_LOG2)
    ) respFifo (                            // Drive in, CPU out
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (1'b0),
        .i_push  (i_drive.respWrite),
        .i_wData (i_drive.respData),
        .i_pop   (respPop),
        .o_rData (respData),
        .o_valid (respValid),
        .o_full  ()                         // Drive side has no full flag
    );

    // ----------------------------------------
    // Audio
    // ----------------------------------------
    audioMixer #(
        .SAMPLE_PERIOD  (SAMPLE_PERIOD),
        .PCM_DEPTH_LOG2 (PCM_DEPTH_LOG2)
    ) mixer (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_volume      (volume),
        .i_pcmWriteL   (i_drive.pcmWriteL),
        .i_pcmWriteR   (i_drive.pcmWriteR),
        .i_pcmL        (i_drive.pcmL),
        .i_pcmR        (i_drive.pcmR),
        .o_pcmFull     (pcmFull),
        .o_outL        (o_outL),
        .o_outR        (o_outR),
        .o_sampleValid (o_sampleValid)
    );

endmodule

`default_nettype wire

//--- hdl/cdromPkg.sv
/*
 * Host-side package for the CD front end
 * Register map, bank index, host bus and drive-side structs
 */
`default_nettype none

package cdromPkg;

    // ----------------------------------------
    // Host bus types
    // ----------------------------------------
    typedef logic [1:0] hostAdr_t;      // CPU register address
    typedef logic [1:0] regIndex_t;     // Bank select
    typedef logic [7:0] hostByte_t;

    // Register addresses
    localparam hostAdr_t ADR_STATUS   = 2'd0;
    localparam hostAdr_t ADR_RESPONSE = 2'd1;
    localparam hostAdr_t ADR_PARAM    = 2'd2;
    localparam hostAdr_t ADR_CONTROL  = 2'd3;

    // Status byte layout
    localparam int STAT_PARAM_EMPTY_BIT   = 3;
    localparam int STAT_PARAM_NOTFULL_BIT = 4;
    localparam int STAT_RESP_NOTEMPTY_BIT = 5;

    // Control write bits
    localparam int PARAM_CLEAR_BIT = 6;     // At (3, 1)
    localparam int VOL_APPLY_BIT   = 5;     // At (3, 3)

    // Param and response FIFOs, 16 entries each
    localparam int CMD_FIFO_DEPTH_LOG2 = 4;

    typedef struct packed {
        logic      cs;
        logic      write;
        logic      read;
        hostAdr_t  adr;
        hostByte_t data;
    } hostBus_t;

    // ----------------------------------------
    // Drive side
    // ----------------------------------------
    typedef struct packed {
        logic              paramRead;   // Pop strobe, param FIFO
        logic              respWrite;   // Push strobe, response FIFO
        hostByte_t         respData;
        logic              pcmWriteL;
        logic              pcmWriteR;
        audioPkg::sample_t pcmL;
        audioPkg::sample_t pcmR;
    } driveIn_t;

    typedef struct packed {
        hostByte_t paramData;           // Param FIFO head
        logic      paramValid;
        logic      pcmFull;             // Either PCM FIFO full
    } driveOut_t;

endpackage

`default_nettype wire

//--- hdl/hostRegisters.sv
/*
 * Host register block
 * Decodes CPU accesses against the bank index, holds index,
 * interrupt enable and the staged and working volumes,
 * and drives the FIFO strobes and the read mux
 */
`timescale 1ns/1ns
`default_nettype none

module hostRegisters
    import cdromPkg::*;
    import audioPkg::*;
(
    input  wire             i_clk,
    input  wire             i_nrst,
    input  hostBus_t        i_bus,
    output hostByte_t       o_dataOut,
    // Parameter FIFO
    input  wire             i_paramFull,
    input  wire             i_paramValid,
    output logic            o_paramPush,
    output logic            o_paramClear,
    // Response FIFO
    input  hostByte_t       i_respData,
    input  wire             i_respValid,
    output logic            o_respPop,
    // To the mixer
    output mixVolume_t      o_volume
);

    logic       wrStb;
    logic       rdStb;
    logic       volApply;
    regIndex_t  index;
    hostByte_t  intEnable;
    mixVolume_t staged;         // Written by the CPU
    mixVolume_t working;        // Seen by the mixer
    hostByte_t  statusByte;

    // ----------------------------------------
    // Access decode
    // ----------------------------------------
    assign wrStb = i_bus.cs && i_bus.write;
    assign rdStb = i_bus.cs && i_bus.read;

    assign o_paramPush  = wrStb && (i_bus.adr == ADR_PARAM) && (index == 2'd0);
    assign o_paramClear = wrStb && (i_bus.adr == ADR_CONTROL) && (index == 2'd1)
                          && i_bus.data[PARAM_CLEAR_BIT];
    assign volApply     = wrStb && (i_bus.adr == ADR_CONTROL) && (index == 2'd3)
                          && i_bus.data[VOL_APPLY_BIT];

    // Response read, any bank; never pops an empty FIFO
    assign o_respPop = rdStb && (i_bus.adr == ADR_RESPONSE) && i_respValid;

    assign o_volume = working;

    // ----------------------------------------
    // Register writes
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_nrst) begin
            index     <= '0;
            intEnable <= '0;
            staged    <= '0;
        end else if (wrStb) begin
            case (i_bus.adr)
                ADR_STATUS: index <= i_bus.data[1:0];
                ADR_RESPONSE: begin
                    if (index == 2'd3) begin
                        staged.rr <= i_bus.data;
                    end
                end
                ADR_PARAM: begin
                    case (index)
                        2'd1:    intEnable <= i_bus.data;   // All 8 bits kept
                        2'd2:    staged.ll <= i_bus.data;
                        2'd3:    staged.rl <= i_bus.data;
                        default: ;                          // Param push, see decode
                    endcase
                end
                ADR_CONTROL: begin
                    if (index == 2'd2) begin
                        staged.lr <= i_bus.data;
                    end
                end
                default: ;
            endcase
        end
    end

    // Staged set only reaches the mixer on apply
    always_ff @(posedge i_clk) begin
        if (!i_nrst) begin
            working <= '0;
        end else if (volApply) begin
            working <= staged;
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        statusByte = '0;                            // Busy, data and ADPCM bits read 0
        statusByte[STAT_RESP_NOTEMPTY_BIT] = i_respValid;
        statusByte[STAT_PARAM_NOTFULL_BIT] = !i_paramFull;
        statusByte[STAT_PARAM_EMPTY_BIT]   = !i_paramValid;
        statusByte[1:0] = index;                    // Bit 2 stays 0
    end

    always_comb begin
        case (i_bus.adr)
            ADR_STATUS:   o_dataOut = statusByte;
            ADR_RESPONSE: o_dataOut = i_respValid ? i_respData : 8'h00;  // Empty reads 00h
            ADR_PARAM:    o_dataOut = 8'h00;        // No data FIFO
            default: begin
                // Interrupt enable on even banks only
                o_dataOut = index[0] ? 8'h00 : intEnable;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/syncFifo.sv
/*
 * Synchronous FIFO, first word falls through
 * Head always on o_rData, single-cycle clear,
 * push and pop allowed in the same cycle
 */
`timescale 1ns/1ns
`default_nettype none

module syncFifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  wire                   i_clk,
    input  wire                   i_nrst,
    input  wire                   i_clear,
    input  wire                   i_push,
    input  wire  [DATA_WIDTH-1:0] i_wData,
    input  wire                   i_pop,
    output logic [DATA_WIDTH-1:0] o_rData,
    output logic                  o_valid,
    output logic                  o_full
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] rdPtr;
    logic [DEPTH_LOG2:0]   count;   // One extra bit so full is representable
    logic                  doPush;
    logic                  doPop;

    // Overflow and underflow attempts are dropped
    assign doPush = i_push && !o_full;
    assign doPop  = i_pop && o_valid;

    assign o_valid = |count;
    assign o_full  = count[DEPTH_LOG2];     // MSB only set at DEPTH
    assign o_rData = mem[rdPtr];

    always_ff @(posedge i_clk) begin
        if (!i_nrst || i_clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;  // Wraps at DEPTH
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge i_clk) begin
        if (doPush) begin
            mem[wrPtr] <= i_wData;
        end
    end

endmodule

`default_nettype wire

//--- project.f
hdl/audioPkg.sv
hdl/cdromPkg.sv
hdl/syncFifo.sv
hdl/hostRegisters.sv
hdl/audioMixer.sv
hdl/cdromFrontEnd.sv
verification/cdromFrontEnd_properties.sv
verification/cdromFrontEnd_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CD front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=cdromFrontEnd_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f project.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- verification/cdromFrontEnd_properties.sv
/*
 * Bound checks for the audio mixer and the host register block
 * Strobe spacing, pops only from a valid FIFO, quiet outputs after reset
 */
`timescale 1ns/1ns
`default_nettype none

module cdromFrontEnd_properties #(
    parameter int SAMPLE_PERIOD = 768
) (
    input wire i_clk,
    input wire i_nrst,
    input wire i_strobe,        // Output sample strobe, tied 0 where absent
    input wire i_popA,
    input wire i_validA,
    input wire i_popB,
    input wire i_validB
);

    int unsigned cyclesSinceStrobe;
    logic        strobeSeen;    // First strobe has no reference

    // Cycle count since the last strobe
    always_ff @(posedge i_clk) begin
        if (!i_nrst) begin
            cyclesSinceStrobe <= 0;
            strobeSeen        <= 1'b0;
        end else if (i_strobe) begin
            cyclesSinceStrobe <= 1;
            strobeSeen        <= 1'b1;
        end else begin
            cyclesSinceStrobe <= cyclesSinceStrobe + 1;
        end
    end

    strobeSpacing: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_strobe && strobeSeen) |-> (cyclesSinceStrobe == SAMPLE_PERIOD))
        else $error("sample strobes are not %0d cycles apart", SAMPLE_PERIOD);

    popValidA: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_popA |-> i_validA)
        else $error("pop from an empty FIFO (A)");

    popValidB: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_popB |-> i_validB)
        else $error("pop from an empty FIFO (B)");

    // Nothing fires in the first cycle out of reset
    quietAfterReset: assert property (@(posedge i_clk)
        !i_nrst |=> !(i_strobe || i_popA || i_popB))
        else $error("strobe or pop active right after reset");

endmodule

// Pops observed at the PCM FIFO inputs
bind audioMixer cdromFrontEnd_properties #(.SAMPLE_PERIOD(SAMPLE_PERIOD)) mixerChecks (
    .i_clk    (i_clk),
    .i_nrst   (i_nrst),
    .i_strobe (o_sampleValid),
    .i_popA   (pcmFifoL.i_pop),
    .i_validA (pcmFifoL.o_valid),
    .i_popB   (pcmFifoR.i_pop),
    .i_validB (pcmFifoR.o_valid)
);

// Response pop only, no strobe here
bind hostRegisters cdromFrontEnd_properties #(.SAMPLE_PERIOD(1)) regChecks (
    .i_clk    (i_clk),
    .i_nrst   (i_nrst),
    .i_strobe (1'b0),
    .i_popA   (o_respPop),
    .i_validA (i_respValid),
    .i_popB   (1'b0),
    .i_validB (1'b1)
);

`default_nettype wire

//--- verification/cdromFrontEnd_tb.sv
/*
 * Testbench for the CD drive host front end
 * Host registers, command FIFOs, volume staging and the mixer,
 * with the mixer driven from a table of samples and expected outputs
 */
`timescale 1ns/1ns
`default_nettype none

module cdromFrontEnd_tb
    import cdromPkg::*;
    import audioPkg::*;
();

    localparam int SAMPLE_PERIOD  = 32;
    localparam int PCM_DEPTH_LOG2 = 3;
    localparam int CLK_PERIOD     = 20;     // ns
    localparam int NUM_FIXED      = 10;
    localparam int NUM_RANDOM     = 8;
    localparam int NUM_ROWS       = NUM_FIXED + NUM_RANDOM;
    // Table rows plus register tests, sync and PCM full check
    localparam int TIMEOUT_NS = (NUM_ROWS + 12) * SAMPLE_PERIOD * CLK_PERIOD + 2000;

    typedef struct packed {
        mixVolume_t vol;
        logic       apply;      // Copy staged set to working
        sample_t    l;
        sample_t    r;
        sample_t    expL;
        sample_t    expR;
    } mixRow_t;

    logic        clk;
    logic        nrst;
    hostBus_t    hostBus;
    hostByte_t   dataOut;
    driveIn_t    driveIn;
    driveOut_t   driveOut;
    sample_t     outL;
    sample_t     outR;
    logic        sampleValid;
    mixRow_t     rows [NUM_ROWS];
    int          errorCount = 0;
    int          checkCount = 0;
    int unsigned seedValue;

    cdromFrontEnd #(
        .SAMPLE_PERIOD  (SAMPLE_PERIOD),
        .PCM_DEPTH_LOG2 (PCM_DEPTH_LOG2)
    ) uut (
        .i_clk         (clk),
        .i_nrst        (nrst),
        .i_bus         (hostBus),
        .o_dataOut     (dataOut),
        .i_drive       (driveIn),
        .o_drive       (driveOut),
        .o_outL        (outL),
        .o_outR        (outR),
        .o_sampleValid (sampleValid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic compareValue(input string name, input logic [15:0] got,
                                input logic [15:0] want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("Fail %s: got %h, expected %h at %0t ns", name, got, want, $time);
        end
    endtask

    task automatic writeReg(input hostAdr_t adr, input hostByte_t data);
        @(posedge clk);
        hostBus <= '{cs: 1'b1, write: 1'b1, read: 1'b0, adr: adr, data: data};
        @(posedge clk);
        hostBus <= '0;
    endtask

    // Read data sampled mid-cycle, pop lands on the next edge
    task automatic readReg(input hostAdr_t adr, output hostByte_t data);
        @(posedge clk);
        hostBus <= '{cs: 1'b1, write: 1'b0, read: 1'b1, adr: adr, data: 8'h00};
        @(negedge clk);
        data = dataOut;
        @(posedge clk);
        hostBus <= '0;
    endtask

    task automatic readExpect(input hostAdr_t adr, input hostByte_t want, input string name);
        hostByte_t got;
        readReg(adr, got);
        compareValue(name, 16'(got), 16'(want));
    endtask

    task automatic selectBank(input regIndex_t bank);
        writeReg(ADR_STATUS, {6'b0, bank});
    endtask

    task automatic pushResponse(input hostByte_t data);
        @(posedge clk);
        driveIn.respWrite <= 1'b1;
        driveIn.respData  <= data;
        @(posedge clk);
        driveIn.respWrite <= 1'b0;
    endtask

    task automatic popParam();
        @(posedge clk);
        driveIn.paramRead <= 1'b1;
        @(posedge clk);
        driveIn.paramRead <= 1'b0;
    endtask

    task automatic pushPcm(input logic left, input logic right, input sample_t l,
                           input sample_t r);
        @(posedge clk);
        driveIn.pcmWriteL <= left;
        driveIn.pcmWriteR <= right;
        driveIn.pcmL      <= l;
        driveIn.pcmR      <= r;
        @(posedge clk);
        driveIn.pcmWriteL <= 1'b0;
        driveIn.pcmWriteR <= 1'b0;
    endtask

    task automatic awaitStrobe();
        do begin
            @(negedge clk);
        end while (!sampleValid);
    endtask

    // Reference mix of one output channel
    function automatic sample_t mixModel(input volume_t gainA, input sample_t inA,
                                         input volume_t gainB, input sample_t inB);
        int total;
        total = ((int'(gainA) * int'(inA)) >>> 7) + ((int'(gainB) * int'(inB)) >>> 7);
        if (total > 32767) begin
            total = 32767;
        end else if (total < -32768) begin
            total = -32768;
        end
        return sample_t'(total);
    endfunction

    function automatic mixRow_t makeRow(input volume_t ll, input volume_t lr,
                                        input volume_t rl, input volume_t rr,
                                        input logic apply, input sample_t l, input sample_t r,
                                        input sample_t expL, input sample_t expR);
        mixRow_t row;
        row.vol   = '{ll: ll, lr: lr, rl: rl, rr: rr};
        row.apply = apply;
        row.l     = l;
        row.r     = r;
        row.expL  = expL;
        row.expR  = expR;
        return row;
    endfunction

    // ----------------------------------------
    // Mix table
    // ----------------------------------------
    task automatic buildTable();
        mixVolume_t vol;
        sample_t    l;
        sample_t    r;
        rows[0] = makeRow(8'h80, 8'h00, 8'h00, 8'h80, 1'b0, 16'sd1000, -16'sd2000,
                          16'h0000, 16'h0000);      // Staged only, working still 0
        rows[1] = makeRow(8'h80, 8'h00, 8'h00, 8'h80, 1'b1, 16'h1234, -16'sd2000,
                          16'h1234, 16'hF830);      // Unity, straight through
        rows[2] = makeRow(8'h40, 8'h40, 8'h40, 8'h40, 1'b1, 16'sd1000, 16'sd3000,
                          16'h07D0, 16'h07D0);
        rows[3] = makeRow(8'hFF, 8'hFF, 8'hFF, 8'hFF, 1'b1, 16'sd30000, 16'sd30000,
                          16'h7FFF, 16'h7FFF);      // Positive clip
        rows[4] = makeRow(8'hFF, 8'hFF, 8'hFF, 8'hFF, 1'b1, -16'sd30000, -16'sd30000,
                          16'h8000, 16'h8000);      // Negative clip
        rows[5] = makeRow(8'h00, 8'h80, 8'h80, 8'h00, 1'b1, 16'sd100, -16'sd100,
                          16'hFF9C, 16'h0064);      // Channels swapped
        rows[6] = makeRow(8'h80, 8'h80, 8'h80, 8'h80, 1'b0, 16'sd200, 16'sd300,
                          16'h012C, 16'h00C8);      // Swap set still active
        rows[7] = makeRow(8'h80, 8'h80, 8'h80, 8'h80, 1'b1, 16'sd200, 16'sd300,
                          16'h01F4, 16'h01F4);
        rows[8] = makeRow(8'h01, 8'h00, 8'h00, 8'h01, 1'b1, -16'sd1, 16'sd1,
                          16'hFFFF, 16'h0000);      // Shift rounds toward minus
        rows[9] = makeRow(8'h80, 8'h80, 8'h80, 8'h80, 1'b1, 16'h7FFF, 16'sd1,
                          16'h7FFF, 16'h7FFF);      // One past the top
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            vol = mixVolume_t'($urandom);
            l   = sample_t'($urandom);
            r   = sample_t'($urandom);
            rows[i] = makeRow(vol.ll, vol.lr, vol.rl, vol.rr, 1'b1, l, r,
                              mixModel(vol.ll, l, vol.rl, r), mixModel(vol.lr, l, vol.rr, r));
        end
    endtask

    // Stage volumes, optionally apply, play one sample pair
    task automatic runRow(input int idx, input mixRow_t row);
        selectBank(2'd2);
        writeReg(ADR_PARAM, row.vol.ll);
        writeReg(ADR_CONTROL, row.vol.lr);
        selectBank(2'd3);
        writeReg(ADR_PARAM, row.vol.rl);
        writeReg(ADR_RESPONSE, row.vol.rr);
        if (row.apply) begin
            writeReg(ADR_CONTROL, 8'h20);       // Bit 5
        end
        pushPcm(1'b1, 1'b1, row.l, row.r);
        awaitStrobe();
        compareValue($sformatf("o_outL row %0d", idx), outL, row.expL);
        compareValue($sformatf("o_outR row %0d", idx), outR, row.expR);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        hostBus   = '0;
        driveIn   = '0;
        nrst      = 1'b0;
        seedValue = $urandom(32'h00e4_d914);
        buildTable();
        repeat (10) @(posedge clk);
        nrst <= 1'b1;

        // After reset
        readExpect(ADR_STATUS, 8'h18, "o_dataOut status after reset");
        @(negedge clk);
        compareValue("o_drive.pcmFull", 16'(driveOut.pcmFull), 16'h0);
        compareValue("o_drive.paramValid", 16'(driveOut.paramValid), 16'h0);
        awaitStrobe();
        compareValue("o_outL first strobe", outL, 16'h0000);
        compareValue("o_outR first strobe", outR, 16'h0000);

        // Parameter FIFO, fill to 16
        for (int i = 0; i < 16; i++) begin
            writeReg(ADR_PARAM, 8'hA0 + 8'(i));
            readExpect(ADR_STATUS, (i < 15) ? 8'h10 : 8'h00, "o_dataOut param status");
        end
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            compareValue("o_drive.paramValid", 16'(driveOut.paramValid), 16'h1);
            compareValue("o_drive.paramData", 16'(driveOut.paramData), 16'(8'hA0 + 8'(i)));
            popParam();
        end
        readExpect(ADR_STATUS, 8'h10, "o_dataOut status after pops");
        selectBank(2'd1);
        writeReg(ADR_CONTROL, 8'h40);           // Clear bit 6
        @(negedge clk);
        compareValue("o_drive.paramValid after clear", 16'(driveOut.paramValid), 16'h0);
        readExpect(ADR_STATUS, 8'h19, "o_dataOut status after clear");
        selectBank(2'd0);

        // Response FIFO
        pushResponse(8'hC1);
        pushResponse(8'hC2);
        pushResponse(8'hC3);
        readExpect(ADR_STATUS, 8'h38, "o_dataOut status resp pending");
        readExpect(ADR_RESPONSE, 8'hC1, "o_dataOut response 0");
        readExpect(ADR_RESPONSE, 8'hC2, "o_dataOut response 1");
        readExpect(ADR_RESPONSE, 8'hC3, "o_dataOut response 2");
        readExpect(ADR_STATUS, 8'h18, "o_dataOut status resp drained");
        readExpect(ADR_RESPONSE, 8'h00, "o_dataOut response empty");

        // Interrupt enable and index readback
        selectBank(2'd1);
        writeReg(ADR_PARAM, 8'h5A);
        for (int b = 0; b < 4; b++) begin
            selectBank(regIndex_t'(b));
            readExpect(ADR_CONTROL, b[0] ? 8'h00 : 8'h5A, "o_dataOut int enable");
            readExpect(ADR_STATUS, 8'h18 | 8'(b), "o_dataOut status index");
        end
        selectBank(2'd0);

        // Volume staging and mixing, aligned to a strobe first
        awaitStrobe();
        for (int i = 0; i < NUM_ROWS; i++) begin
            runRow(i, rows[i]);
        end

        // PCM FIFO full on the left side only
        for (int i = 0; i < 8; i++) begin
            pushPcm(1'b1, 1'b0, sample_t'(i), 16'sd0);
            @(negedge clk);
            compareValue("o_drive.pcmFull filling", 16'(driveOut.pcmFull),
                         (i == 7) ? 16'h1 : 16'h0);
        end
        awaitStrobe();
        compareValue("o_drive.pcmFull after strobe", 16'(driveOut.pcmFull), 16'h0);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
